//--- mem_pkg.sv
// ------------------------------------------------------------
// memory subsystem shared definitions
// address views, region codes, flash timing and RAM size
// ------------------------------------------------------------

`default_nettype none

package mem_pkg;

  // bus byte address width
  localparam int ADDR_W = 24;

  // region codes carried in address bit 23
  localparam logic REGION_ROM = 1'b0;
  localparam logic REGION_RAM = 1'b1;

  // flash access time per byte, in clock cycles
  localparam int FLASH_WAIT = 5;

  // stb sample to ack: four byte cycles plus the ack cycle
  localparam int ROM_ACK_LAT = 4 * (FLASH_WAIT + 1) + 1;

  // on-chip RAM size in 32-bit words
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW = $clog2(RAM_WORDS);

  // word index width inside the 8 MB flash region
  localparam int ROM_WORD_W = ADDR_W - 3;

  // one bus address seen two ways
  typedef union packed {
    struct packed {
      logic                  region;
      logic [ROM_WORD_W-1:0] rom_word;
      logic [1:0]            byte_sel;
    } rom;
    struct packed {
      logic                           region;
      logic [ADDR_W-RAM_AW-4:0]       unused;
      logic [RAM_AW-1:0]              ram_word;
      logic [1:0]                     byte_sel;
    } ram;
  } bus_addr_u;

endpackage

`default_nettype wire

//--- flash_rom_ctrl.sv
// ------------------------------------------------------------
// flash ROM read controller
// four timed byte reads per 32-bit word, MSB first
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module flash_rom_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               stb,
  input  mem_pkg::bus_addr_u addr,
  input  logic [7:0]         flash_d,
  output logic [31:0]        rdata,
  output logic               ack,
  output logic [22:0]        flash_a,
  output logic               flash_ce_n,
  output logic               flash_oe_n
);

  localparam int CYC_W = $clog2(mem_pkg::FLASH_WAIT + 1);

  logic             active;
  logic [CYC_W-1:0] cyc;
  logic [1:0]       byte_idx;
  logic             byte_done;

  // access time for the current byte has passed
  assign byte_done = (cyc == CYC_W'(mem_pkg::FLASH_WAIT));

  // low address bits come from the sequencer, not the bus
  assign flash_a = {addr.rom.rom_word, byte_idx};

  // chip and output enable only while bytes are being read
  assign flash_ce_n = ~active;
  assign flash_oe_n = ~active;

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      ack      <= 1'b0;
      cyc      <= '0;
      byte_idx <= 2'd0;
    end else begin
      ack <= 1'b0;
      if (!active) begin
        // a held stb during the ack cycle must not restart
        if (stb && !ack) begin
          active   <= 1'b1;
          cyc      <= '0;
          byte_idx <= 2'd0;
        end
      end else if (byte_done) begin
        cyc <= '0;
        if (byte_idx == 2'd3) begin
          active <= 1'b0;
          ack    <= 1'b1;
        end else begin
          byte_idx <= byte_idx + 2'd1;
        end
      end else begin
        cyc <= cyc + 1'b1;
      end
    end
  end

  // shift each byte in at the bottom, first byte ends up on top
  always_ff @(posedge clk) begin
    if (active && byte_done) begin
      rdata <= {rdata[23:0], flash_d};
    end
  end

  // ack is a single-cycle pulse
  ack_one_cycle: assert property (
    @(posedge clk) disable iff (rst)
    ack |=> !ack
  ) else $error("flash_rom_ctrl: ack held for more than one cycle");

  // the master must not start a new request mid-sequence
  no_stb_rise_busy: assert property (
    @(posedge clk) disable iff (rst)
    active |-> !$rose(stb)
  ) else $error("flash_rom_ctrl: stb rose while a flash read was active");

endmodule

`default_nettype wire

//--- word_ram.sv
// ------------------------------------------------------------
// on-chip word RAM, 1024 x 32
// single-cycle read or write with a registered ack
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module word_ram (
  input  logic               clk,
  input  logic               rst,
  input  logic               stb,
  input  logic               we,
  input  mem_pkg::bus_addr_u addr,
  input  logic [31:0]        wdata,
  output logic [31:0]        rdata,
  output logic               ack
);

  logic [31:0] mem [mem_pkg::RAM_WORDS];

  logic access;

  // the cycle after an ack still sees stb, so skip it
  assign access = stb && !ack;

  always_ff @(posedge clk) begin
    if (access) begin
      if (we) begin
        mem[addr.ram.ram_word] <= wdata;
      end else begin
        rdata <= mem[addr.ram.ram_word];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

endmodule

`default_nettype wire

//--- mem_decoder.sv
// ------------------------------------------------------------
// address decoder for the ROM and RAM regions
// strobe routing, return mux, ROM write sink
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mem_decoder (
  input  logic               clk,
  input  logic               rst,
  input  logic               stb,
  input  logic               we,
  input  mem_pkg::bus_addr_u addr,
  input  logic [31:0]        rom_rdata,
  input  logic [31:0]        ram_rdata,
  input  logic               rom_ack,
  input  logic               ram_ack,
  output logic               rom_stb,
  output logic               ram_stb,
  output logic [31:0]        rdata,
  output logic               ack
);

  logic is_rom;
  logic rom_wr;
  logic wr_ack;

  assign is_rom = (addr.rom.region == mem_pkg::REGION_ROM);

  // flash is read-only, writes never reach it
  assign rom_stb = stb && !we && is_rom;
  assign ram_stb = stb && (addr.rom.region == mem_pkg::REGION_RAM);
  assign rom_wr  = stb && we && is_rom;

  // dropped ROM write, acked here one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ack <= 1'b0;
    end else begin
      wr_ack <= rom_wr && !wr_ack;
    end
  end

  always_comb begin
    if (is_rom) begin
      ack   = rom_ack || wr_ack;
      rdata = wr_ack ? 32'd0 : rom_rdata;
    end else begin
      ack   = ram_ack;
      rdata = ram_rdata;
    end
  end

  // one request reaches one slave, the strobes never meet in adjacent cycles
  one_slave_stb: assert property (
    @(posedge clk) disable iff (rst)
    !(ram_stb && $past(rom_stb)) && !(rom_stb && $past(ram_stb))
  ) else $error("mem_decoder: strobe moved between ROM and RAM without a break");

  // acks from the two slaves must never overlap
  no_ack_overlap: assert property (
    @(posedge clk) disable iff (rst)
    !(rom_ack && ram_ack)
  ) else $error("mem_decoder: ROM and RAM acks in the same cycle");

endmodule

`default_nettype wire

//--- mem_subsys.sv
// ------------------------------------------------------------
// memory subsystem top level
// decoder, flash ROM controller and word RAM on one bus
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       stb,
  input  logic                       we,
  input  logic [mem_pkg::ADDR_W-1:0] addr,
  input  logic [31:0]                wdata,
  input  logic [7:0]                 flash_d,
  output logic [31:0]                rdata,
  output logic                       ack,
  output logic [22:0]                flash_a,
  output logic                       flash_ce_n,
  output logic                       flash_oe_n
);

  logic        rom_stb;
  logic        ram_stb;
  logic [31:0] rom_rdata;
  logic [31:0] ram_rdata;
  logic        rom_ack;
  logic        ram_ack;

  mem_decoder u_decoder (
    .clk       (clk),
    .rst       (rst),
    .stb       (stb),
    .we        (we),
    .addr      (addr),
    .rom_rdata (rom_rdata),
    .ram_rdata (ram_rdata),
    .rom_ack   (rom_ack),
    .ram_ack   (ram_ack),
    .rom_stb   (rom_stb),
    .ram_stb   (ram_stb),
    .rdata     (rdata),
    .ack       (ack)
  );

  // region 0, 8 MB byte-wide flash
  flash_rom_ctrl u_rom (
    .clk        (clk),
    .rst        (rst),
    .stb        (rom_stb),
    .addr       (addr),
    .flash_d    (flash_d),
    .rdata      (rom_rdata),
    .ack        (rom_ack),
    .flash_a    (flash_a),
    .flash_ce_n (flash_ce_n),
    .flash_oe_n (flash_oe_n)
  );

  // region 1, 4 KB on-chip RAM
  word_ram u_ram (
    .clk   (clk),
    .rst   (rst),
    .stb   (ram_stb),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .rdata (ram_rdata),
    .ack   (ram_ack)
  );

endmodule

`default_nettype wire

//--- flash_model.sv
// ------------------------------------------------------------
// behavioral byte-wide flash for simulation
// content is computed from the byte address
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module flash_model (
  input  logic [22:0] flash_a,
  input  logic        flash_ce_n,
  input  logic        flash_oe_n,
  output logic [7:0]  flash_d
);

  // byte x holds the low 8 bits of x * 7 + 3
  function automatic logic [7:0] byte_at(input logic [22:0] x);
    logic [25:0] val;
    val = {3'b000, x} * 26'd7 + 26'd3;
    return val[7:0];
  endfunction

  // data bus reads as zero unless the part is selected and enabled
  assign flash_d = (flash_ce_n || flash_oe_n) ? 8'h00 : byte_at(flash_a);

endmodule

`default_nettype wire

//--- mem_checker.sv
// ------------------------------------------------------------
// bus monitor for the memory subsystem
// checks ack latency, read data, flash enables and flash address
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module mem_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        stb,
  input  logic        we,
  input  logic [23:0] addr,
  input  logic [31:0] rdata,
  input  logic        ack,
  input  logic [22:0] flash_a,
  input  logic        flash_ce_n,
  input  logic        flash_oe_n,
  output int          errors,
  output int          checked
);

  int          fd;
  int          cyc;
  int          exp_lat;
  logic        stb_q;
  logic        busy;
  logic        rom_rd;
  logic        flash_on;
  logic        open_reported;
  bit          found;
  logic [7:0]  e_op;
  logic [23:0] e_addr;
  logic [31:0] e_wdata;
  logic [31:0] e_rdata;
  logic [22:0] exp_fa;

  initial begin
    fd = $fopen("mem_tests.txt", "r");
  end

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errors = errors + 1;
  endtask

  // next R or W line, comment lines skipped
  task automatic next_expected(output bit ok, output logic [7:0] op, output logic [23:0] a,
                               output logic [31:0] w, output logic [31:0] r);
    string line;
    int    n;
    ok = 1'b0;
    while (!ok && fd != 0 && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%c %h %h %h", op, a, w, r);
        if (n == 4 && (op == "R" || op == "W")) ok = 1'b1;
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      errors        = 0;
      checked       = 0;
      busy          = 1'b0;
      stb_q         = 1'b0;
      rom_rd        = 1'b0;
      cyc           = 0;
      open_reported = 1'b0;
    end else begin
      if (fd == 0 && !open_reported) begin
        $display("checker could not open mem_tests.txt");
        errors        = errors + 1;
        open_reported = 1'b1;
      end
      if (busy) cyc = cyc + 1;
      // a new request starts where stb is first seen high
      if (stb && !stb_q && !busy) begin
        busy   = 1'b1;
        cyc    = 0;
        rom_rd = !we && (addr[23] == mem_pkg::REGION_ROM);
      end
      // flash selected from the first byte cycle to the last byte capture
      flash_on = busy && rom_rd && cyc >= 1 && cyc <= mem_pkg::ROM_ACK_LAT - 1;
      if (flash_ce_n != !flash_on || flash_oe_n != !flash_on) begin
        fail_check($sformatf("flash enables ce_n=%b oe_n=%b, expected %b",
                             flash_ce_n, flash_oe_n, !flash_on));
      end
      // byte address steps 0 to 3, one step per byte cycle
      if (flash_on) begin
        exp_fa = {addr[22:2], 2'((cyc - 1) / (mem_pkg::FLASH_WAIT + 1))};
        if (flash_a !== exp_fa) begin
          fail_check($sformatf("flash address %h in cycle %0d of read %h, expected %h",
                               flash_a, cyc, addr, exp_fa));
        end
      end
      if (ack && !busy) begin
        fail_check("ack with no request outstanding");
      end else if (ack) begin
        next_expected(found, e_op, e_addr, e_wdata, e_rdata);
        if (!found) begin
          fail_check("ack beyond the end of the test list");
        end else begin
          exp_lat = (e_op == "R" && e_addr[23] == mem_pkg::REGION_ROM) ?
                    mem_pkg::ROM_ACK_LAT : 1;
          if (addr != e_addr || we != (e_op == "W")) begin
            fail_check($sformatf("bus request %h we=%b out of step with list entry %c %h",
                                 addr, we, e_op, e_addr));
          end
          if (cyc != exp_lat) begin
            fail_check($sformatf("ack for %h after %0d cycles, expected %0d",
                                 addr, cyc, exp_lat));
          end
          // RAM writes return stale data, everything else is compared
          if (!(e_op == "W" && e_addr[23] == mem_pkg::REGION_RAM) && rdata !== e_rdata) begin
            fail_check($sformatf("%c %h returned %h, expected %h",
                                 e_op, e_addr, rdata, e_rdata));
          end
          checked = checked + 1;
        end
        busy = 1'b0;
      end
      stb_q = stb;
    end
  end

endmodule

`default_nettype wire

//--- tb_mem_subsys.sv
// ------------------------------------------------------------
// testbench for the memory subsystem
// clock, reset, requests from mem_tests.txt, final verdict
// ------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

  localparam int ACK_TIMEOUT = 60;

  logic        clk;
  logic        rst;
  logic        stb;
  logic        we;
  logic [23:0] addr;
  logic [31:0] wdata;
  logic [7:0]  flash_d;
  logic [31:0] rdata;
  logic        ack;
  logic [22:0] flash_a;
  logic        flash_ce_n;
  logic        flash_oe_n;

  int check_errors;
  int checked;
  int timeouts;
  int other_errors;
  int issued;
  int fd;

  mem_subsys uut (
    .clk        (clk),
    .rst        (rst),
    .stb        (stb),
    .we         (we),
    .addr       (addr),
    .wdata      (wdata),
    .flash_d    (flash_d),
    .rdata      (rdata),
    .ack        (ack),
    .flash_a    (flash_a),
    .flash_ce_n (flash_ce_n),
    .flash_oe_n (flash_oe_n)
  );

  flash_model u_flash (
    .flash_a    (flash_a),
    .flash_ce_n (flash_ce_n),
    .flash_oe_n (flash_oe_n),
    .flash_d    (flash_d)
  );

  mem_checker u_check (
    .clk        (clk),
    .rst        (rst),
    .stb        (stb),
    .we         (we),
    .addr       (addr),
    .rdata      (rdata),
    .ack        (ack),
    .flash_a    (flash_a),
    .flash_ce_n (flash_ce_n),
    .flash_oe_n (flash_oe_n),
    .errors     (check_errors),
    .checked    (checked)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // next R or W line, comment lines skipped
  task automatic read_request(output bit ok, output logic [7:0] op,
                              output logic [23:0] a, output logic [31:0] w);
    string       line;
    logic [31:0] r;
    int          n;
    ok = 1'b0;
    while (!ok && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%c %h %h %h", op, a, w, r);
        if (n == 4 && (op == "R" || op == "W")) ok = 1'b1;
      end
    end
  endtask

  // ack seen in the low phase is the value the next rising edge samples
  task automatic wait_for_ack(output bit seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < ACK_TIMEOUT) begin
      @(negedge clk);
      n = n + 1;
      if (ack) seen = 1'b1;
    end
  endtask

  initial begin
    bit          found;
    bit          seen;
    bit          stop;
    logic [7:0]  op;
    logic [23:0] req_addr;
    logic [31:0] req_wdata;
    int          idle;
    rst          = 1'b1;
    stb          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    wdata        = '0;
    timeouts     = 0;
    other_errors = 0;
    issued       = 0;
    stop         = 1'b0;
    // first call seeds the generator for the idle gaps
    idle = $urandom(37512);
    fd = $fopen("mem_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open mem_tests.txt for reading");
      other_errors = other_errors + 1;
      stop         = 1'b1;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (!stop) begin
      @(negedge clk);
      read_request(found, op, req_addr, req_wdata);
      if (!found) begin
        stop = 1'b1;
      end else begin
        stb    = 1'b1;
        we     = (op == "W");
        addr   = req_addr;
        wdata  = req_wdata;
        issued = issued + 1;
        wait_for_ack(seen);
        // stb stays up through the edge that samples ack
        @(negedge clk);
        stb = 1'b0;
        if (!seen) begin
          $display("no ack within %0d cycles for address %h", ACK_TIMEOUT, req_addr);
          timeouts = timeouts + 1;
          stop     = 1'b1;
        end else begin
          idle = $urandom % 4;
          repeat (idle) @(negedge clk);
        end
      end
    end
    repeat (4) @(negedge clk);
    if (fd != 0) $fclose(fd);
    if (timeouts == 0 && checked != issued) begin
      $display("checker compared %0d acks but %0d requests were issued", checked, issued);
      other_errors = other_errors + 1;
    end
    $display("check errors: %0d  timeouts: %0d  other errors: %0d",
             check_errors, timeouts, other_errors);
    if (check_errors == 0 && timeouts == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mem_tests.txt
# op (R read, W write)  address (24-bit hex)  write data (hex)  expected read data (hex)
# expected data is 0 for ROM-region writes and ignored for RAM writes
R 000000 00000000 030a1118
R 000004 00000000 1f262d34
R 000120 00000000 e3eaf1f8
R 7ffffc 00000000 e7eef5fc
R 000040 00000000 c3cad1d8
W 800000 deadbeef 00000000
W 800ffc 12345678 00000000
W 800010 a5a55a5a 00000000
R 800000 00000000 deadbeef
R 800ffc 00000000 12345678
R 800010 00000000 a5a55a5a
W 000004 ffffffff 00000000
R 000004 00000000 1f262d34
W 0055a8 0badf00d 00000000
R 0055a8 00000000 9ba2a9b0
W 800400 cafe0001 00000000
R 000040 00000000 c3cad1d8
R 800400 00000000 cafe0001
R 000000 00000000 030a1118
R 800000 00000000 deadbeef
W 800004 00000001 00000000
R 7ffffc 00000000 e7eef5fc
R 800004 00000000 00000001
R 800ffc 00000000 12345678
W 800ffc 87654321 00000000
R 800ffc 00000000 87654321
R 000120 00000000 e3eaf1f8
R 800010 00000000 a5a55a5a
W 7ffffc 00000000 00000000
R 7ffffc 00000000 e7eef5fc
R 800000 00000000 deadbeef

//--- compile.f
mem_pkg.sv
flash_rom_ctrl.sv
word_ram.sv
mem_decoder.sv
mem_subsys.sv
flash_model.sv
mem_checker.sv
tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_mem_subsys \
  -f compile.f \
  -o tb_mem_subsys \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_mem_subsys > sim.log 2>&1
cat sim.log

grep -q -F '*** PASSED ***' sim.log && echo "simulation passed" && exit 0
echo "simulation failed, see sim.log"
exit 1
